/* poly_defs.svh */
`ifndef POLY_DEFS_SVH
`define POLY_DEFS_SVH

// polynomial geometry
`define POLY_N              32
`define POLY_Q              3329
`define POLY_BARRETT        5039    // floor(2^24 / q)
`define POLY_STAGES         5
`define POLY_BFLY_LATENCY   3

// command codes on the mode port
`define POLY_MODE_NTT       2'd0
`define POLY_MODE_INTT      2'd1    // reserved, no inverse transform
`define POLY_MODE_LOAD      2'd2
`define POLY_MODE_UNLOAD    2'd3

`endif

/* poly_pkg.sv */
package poly_pkg;

    typedef logic [11:0] coeff_t;   // one coefficient mod q
    typedef logic [4:0]  addr_t;    // coefficient address
    typedef logic [23:0] prod_t;    // full product of two coefficients
    typedef logic [4:0]  tw_idx_t;  // twiddle index, 1 to 31
    typedef logic [1:0]  mode_t;

    // command level FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_NTT,
        ST_UNLOAD
    } ctrl_state_e;

    // butterfly issue FSM
    typedef enum logic [1:0] {
        SQ_IDLE,
        SQ_ISSUE,
        SQ_DRAIN
    } seq_state_e;

endpackage

/* poly_ctrl.sv */
`timescale 1ns/1ps
`include "poly_defs.svh"

module poly_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  poly_pkg::mode_t mode,
    input  logic            run,
    input  logic            data_in_done,
    input  logic            ntt_finish,
    input  logic            unload_last,
    output logic            load_en,
    output logic            ntt_start,
    output logic            unload_start,
    output logic            done
);

    poly_pkg::ctrl_state_e state;
    logic                  finish;      // ending event of the active command

    always_comb begin
        case (state)
            poly_pkg::ST_LOAD:   finish = data_in_done;
            poly_pkg::ST_NTT:    finish = ntt_finish;
            poly_pkg::ST_UNLOAD: finish = unload_last;
            default:             finish = 1'b0;
        endcase
    end

    assign load_en = (state == poly_pkg::ST_LOAD);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= poly_pkg::ST_IDLE;
            ntt_start    <= 1'b0;
            unload_start <= 1'b0;
            done         <= 1'b0;
        end else begin
            ntt_start    <= 1'b0;
            unload_start <= 1'b0;
            done         <= finish;             // one cycle after the end event
            if (state == poly_pkg::ST_IDLE) begin
                if (run) begin
                    case (mode)
                        `POLY_MODE_NTT: begin
                            state     <= poly_pkg::ST_NTT;
                            ntt_start <= 1'b1;
                        end
                        `POLY_MODE_LOAD: state <= poly_pkg::ST_LOAD;
                        `POLY_MODE_UNLOAD: begin
                            state        <= poly_pkg::ST_UNLOAD;
                            unload_start <= 1'b1;
                        end
                        default: state <= poly_pkg::ST_IDLE;  // intt code ignored
                    endcase
                end
            end else if (finish) begin
                state <= poly_pkg::ST_IDLE;
            end
        end
    end

endmodule

/* coeff_bank.sv */
`timescale 1ns/1ps
`include "poly_defs.svh"

module coeff_bank (
    input  logic            clk,
    input  logic            rst,
    input  logic            load_en,
    input  logic            data_in_done,
    input  poly_pkg::coeff_t data_in,
    input  poly_pkg::addr_t data_in_add,
    input  logic            bfly_we,
    input  poly_pkg::addr_t wr_addr_a,
    input  poly_pkg::addr_t wr_addr_b,
    input  poly_pkg::coeff_t wr_data_a,
    input  poly_pkg::coeff_t wr_data_b,
    input  poly_pkg::addr_t rd_addr_a,
    input  poly_pkg::addr_t rd_addr_b,
    input  poly_pkg::addr_t rd_addr_c,
    output poly_pkg::coeff_t rd_data_a,
    output poly_pkg::coeff_t rd_data_b,
    output poly_pkg::coeff_t rd_data_c
);

    poly_pkg::coeff_t mem [`POLY_N];    // one coefficient per entry

    //////////////////////////////////////////////////
    // write side
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `POLY_N; k++) begin
                mem[k] <= '0;
            end
        end else if (load_en && !data_in_done) begin
            mem[data_in_add] <= data_in;    // caller picks the address
        end else if (bfly_we) begin
            // butterfly pair, addresses always differ
            mem[wr_addr_a] <= wr_data_a;
            mem[wr_addr_b] <= wr_data_b;
        end
    end

    //////////////////////////////////////////////////
    // read side, no register
    assign rd_data_a = mem[rd_addr_a];
    assign rd_data_b = mem[rd_addr_b];
    assign rd_data_c = mem[rd_addr_c];     // unload port

endmodule

/* twiddle_rom.sv */
`timescale 1ns/1ps
`include "poly_defs.svh"

// entry k = 296^brv5(k) mod q, 296 being a primitive 64th root
module twiddle_rom (
    input  poly_pkg::tw_idx_t tw_idx,
    output poly_pkg::coeff_t  tw
);

    always_comb begin
        case (tw_idx)
            5'd1:    tw = 12'd1729;     // stage 0
            5'd2:    tw = 12'd2580;     // stage 1
            5'd3:    tw = 12'd3289;
            5'd4:    tw = 12'd2642;     // stage 2
            5'd5:    tw = 12'd630;
            5'd6:    tw = 12'd1897;
            5'd7:    tw = 12'd848;
            5'd8:    tw = 12'd1062;     // stage 3
            5'd9:    tw = 12'd1919;
            5'd10:   tw = 12'd193;
            5'd11:   tw = 12'd797;
            5'd12:   tw = 12'd2786;
            5'd13:   tw = 12'd3260;
            5'd14:   tw = 12'd569;
            5'd15:   tw = 12'd1746;
            5'd16:   tw = 12'd296;      // stage 4
            5'd17:   tw = 12'd2447;
            5'd18:   tw = 12'd1339;
            5'd19:   tw = 12'd1476;
            5'd20:   tw = 12'd3046;
            5'd21:   tw = 12'd56;
            5'd22:   tw = 12'd2240;
            5'd23:   tw = 12'd1333;
            5'd24:   tw = 12'd1426;
            5'd25:   tw = 12'd2094;
            5'd26:   tw = 12'd535;
            5'd27:   tw = 12'd2882;
            5'd28:   tw = 12'd2393;
            5'd29:   tw = 12'd2879;
            5'd30:   tw = 12'd1974;
            5'd31:   tw = 12'd821;
            default: tw = 12'd1;        // index 0 never issued
        endcase
    end

endmodule

/* mod_butterfly.sv */
`timescale 1ns/1ps
`include "poly_defs.svh"

module mod_butterfly (
    input  logic             clk,
    input  logic             rst,
    input  poly_pkg::coeff_t u,
    input  poly_pkg::coeff_t v,
    input  poly_pkg::coeff_t w,
    output poly_pkg::coeff_t s0,
    output poly_pkg::coeff_t s1
);

    localparam logic [12:0] Q       = 13'(`POLY_Q);
    localparam logic [12:0] BARRETT = 13'(`POLY_BARRETT);

    poly_pkg::coeff_t u_q1;
    poly_pkg::prod_t  prod_q1;
    poly_pkg::coeff_t u_q2;
    poly_pkg::coeff_t t_q2;
    logic [36:0]      bar_mul;
    logic [12:0]      bar_quot;
    poly_pkg::prod_t  bar_sub;
    logic [12:0]      bar_rem;
    logic [12:0]      sum;
    logic [12:0]      dif;

    //////////////////////////////////////////////////
    // barrett reduction of the registered product
    assign bar_mul  = prod_q1 * BARRETT;
    assign bar_quot = bar_mul[36:24];                // quotient estimate, low by at most one
    assign bar_sub  = prod_q1 - (poly_pkg::prod_t'(bar_quot) * poly_pkg::prod_t'(Q));
    assign bar_rem  = bar_sub[12:0];                 // below 2q

    // sum and difference of stage 2
    assign sum = {1'b0, u_q2} + {1'b0, t_q2};
    assign dif = {1'b0, u_q2} + Q - {1'b0, t_q2};    // kept positive

    always_ff @(posedge clk) begin
        if (rst) begin
            u_q1    <= '0;
            prod_q1 <= '0;
            u_q2    <= '0;
            t_q2    <= '0;
            s0      <= '0;
            s1      <= '0;
        end else begin
            u_q1    <= u;                            // stage 1
            prod_q1 <= w * v;
            u_q2    <= u_q1;                         // stage 2
            t_q2    <= poly_pkg::coeff_t'((bar_rem >= Q) ? bar_rem - Q : bar_rem);
            s0      <= poly_pkg::coeff_t'((sum >= Q) ? sum - Q : sum);   // stage 3
            s1      <= poly_pkg::coeff_t'((dif >= Q) ? dif - Q : dif);
        end
    end

endmodule

/* ntt_sequencer.sv */
`timescale 1ns/1ps
`include "poly_defs.svh"

module ntt_sequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              ntt_start,
    output poly_pkg::addr_t   rd_addr_a,
    output poly_pkg::addr_t   rd_addr_b,
    output poly_pkg::tw_idx_t tw_idx,
    output logic              bfly_we,
    output poly_pkg::addr_t   wr_addr_a,
    output poly_pkg::addr_t   wr_addr_b,
    output logic              ntt_finish
);

    localparam int         LAT        = `POLY_BFLY_LATENCY;
    localparam logic [2:0] LAST_STAGE = 3'(`POLY_STAGES - 1);
    localparam logic [3:0] LAST_IDX   = 4'(`POLY_N / 2 - 1);

    poly_pkg::seq_state_e state;
    logic [2:0]           s;            // stage
    logic [3:0]           i;            // butterfly within stage
    poly_pkg::addr_t      len;
    poly_pkg::addr_t      grp;
    poly_pkg::addr_t      j;
    logic                 issue;
    logic                 drain_end;
    logic [LAT-1:0]       we_pipe;
    poly_pkg::addr_t      addr_a_pipe [LAT];
    poly_pkg::addr_t      addr_b_pipe [LAT];

    //////////////////////////////////////////////////
    // index math
    assign len = 5'd16 >> s;
    assign grp = {1'b0, i} >> (3'd4 - s);
    assign j   = (grp << (3'd5 - s)) | ({1'b0, i} & (len - 5'd1));

    assign rd_addr_a = j;
    assign rd_addr_b = j + len;
    assign tw_idx    = (5'd1 << s) + grp;    // 2^s + group

    assign issue = (state == poly_pkg::SQ_ISSUE);

    // last write of the stage sits at the pipe output, nothing behind it
    assign drain_end = (state == poly_pkg::SQ_DRAIN) && we_pipe[LAT-1]
                       && (we_pipe[LAT-2:0] == '0);
    assign ntt_finish = drain_end && (s == LAST_STAGE);

    //////////////////////////////////////////////////
    // FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= poly_pkg::SQ_IDLE;
            s     <= '0;
            i     <= '0;
        end else begin
            case (state)
                poly_pkg::SQ_IDLE: begin
                    if (ntt_start) begin
                        state <= poly_pkg::SQ_ISSUE;
                        s     <= '0;
                        i     <= '0;
                    end
                end
                poly_pkg::SQ_ISSUE: begin
                    i <= i + 4'd1;
                    if (i == LAST_IDX) begin
                        state <= poly_pkg::SQ_DRAIN;
                    end
                end
                poly_pkg::SQ_DRAIN: begin
                    if (drain_end) begin
                        i <= '0;
                        if (s == LAST_STAGE) begin
                            state <= poly_pkg::SQ_IDLE;
                        end else begin
                            s     <= s + 3'd1;
                            state <= poly_pkg::SQ_ISSUE;
                        end
                    end
                end
                default: state <= poly_pkg::SQ_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // write-back delay, matches the butterfly depth
    always_ff @(posedge clk) begin
        if (rst) begin
            we_pipe <= '0;
        end else begin
            we_pipe <= {we_pipe[LAT-2:0], issue};
        end
    end

    always_ff @(posedge clk) begin
        addr_a_pipe[0] <= rd_addr_a;
        addr_b_pipe[0] <= rd_addr_b;
        for (int k = 1; k < LAT; k++) begin
            addr_a_pipe[k] <= addr_a_pipe[k-1];
            addr_b_pipe[k] <= addr_b_pipe[k-1];
        end
    end

    assign bfly_we   = we_pipe[LAT-1];
    assign wr_addr_a = addr_a_pipe[LAT-1];
    assign wr_addr_b = addr_b_pipe[LAT-1];

endmodule

/* poly_unloader.sv */
`timescale 1ns/1ps
`include "poly_defs.svh"

module poly_unloader (
    input  logic             clk,
    input  logic             rst,
    input  logic             unload_start,
    input  poly_pkg::coeff_t rd_data_c,
    output poly_pkg::addr_t  rd_addr_c,
    output poly_pkg::coeff_t data_out,
    output logic             data_out_valid,
    output logic             unload_last
);

    localparam poly_pkg::addr_t LAST_ADDR = 5'(`POLY_N - 1);

    poly_pkg::addr_t cnt;     // address shown on data_out

    assign unload_last = data_out_valid && (cnt == LAST_ADDR);
    assign rd_addr_c   = data_out_valid ? cnt + 5'd1 : '0;   // fetch one ahead

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt            <= '0;
            data_out       <= '0;
            data_out_valid <= 1'b0;
        end else if (unload_start) begin
            cnt            <= '0;
            data_out       <= rd_data_c;     // address 0
            data_out_valid <= 1'b1;
        end else if (data_out_valid && !unload_last) begin
            cnt      <= cnt + 5'd1;
            data_out <= rd_data_c;
        end else begin
            cnt            <= '0;
            data_out       <= '0;            // bus quiet when idle
            data_out_valid <= 1'b0;
        end
    end

endmodule

/* poly_unit.sv */
`timescale 1ns/1ps

module poly_unit (
    input  logic             clk,
    input  logic             rst,
    input  poly_pkg::mode_t  mode,
    input  logic             run,
    input  poly_pkg::coeff_t data_in,
    input  poly_pkg::addr_t  data_in_add,
    input  logic             data_in_done,
    output poly_pkg::coeff_t data_out,
    output logic             data_out_valid,
    output logic             done
);

    logic              load_en;
    logic              ntt_start;
    logic              ntt_finish;
    logic              unload_start;
    logic              unload_last;
    logic              bfly_we;
    poly_pkg::addr_t   rd_addr_a;
    poly_pkg::addr_t   rd_addr_b;
    poly_pkg::addr_t   rd_addr_c;
    poly_pkg::addr_t   wr_addr_a;
    poly_pkg::addr_t   wr_addr_b;
    poly_pkg::coeff_t  rd_data_a;
    poly_pkg::coeff_t  rd_data_b;
    poly_pkg::coeff_t  rd_data_c;
    poly_pkg::coeff_t  s0;
    poly_pkg::coeff_t  s1;
    poly_pkg::coeff_t  tw;
    poly_pkg::tw_idx_t tw_idx;

    poly_ctrl i_ctrl (
        .clk, .rst, .mode, .run, .data_in_done, .ntt_finish, .unload_last,
        .load_en, .ntt_start, .unload_start, .done
    );

    coeff_bank i_bank (
        .clk, .rst, .load_en, .data_in_done, .data_in, .data_in_add,
        .bfly_we, .wr_addr_a, .wr_addr_b,
        .wr_data_a (s0),
        .wr_data_b (s1),
        .rd_addr_a, .rd_addr_b, .rd_addr_c,
        .rd_data_a, .rd_data_b, .rd_data_c
    );

    twiddle_rom i_rom (.tw_idx, .tw);

    // read data feeds the butterfly in the same cycle
    mod_butterfly i_bfly (
        .clk, .rst,
        .u  (rd_data_a),
        .v  (rd_data_b),
        .w  (tw),
        .s0, .s1
    );

    ntt_sequencer i_seq (
        .clk, .rst, .ntt_start, .rd_addr_a, .rd_addr_b, .tw_idx,
        .bfly_we, .wr_addr_a, .wr_addr_b, .ntt_finish
    );

    poly_unloader i_unload (
        .clk, .rst, .unload_start, .rd_data_c, .rd_addr_c,
        .data_out, .data_out_valid, .unload_last
    );

endmodule

/* poly_unit_properties.sv */
`timescale 1ns/1ps
`include "poly_defs.svh"

module poly_unit_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  done,
    input poly_pkg::coeff_t      data_out,
    input logic                  data_out_valid,
    input poly_pkg::ctrl_state_e state,
    input poly_pkg::coeff_t      s0,
    input poly_pkg::coeff_t      s1
);

    // done is a single cycle pulse
    done_single_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done held high for two cycles");

    // quiet output bus
    data_zero_when_idle: assert property (@(posedge clk) disable iff (rst)
        !data_out_valid |-> (data_out == '0))
        else $error("data_out nonzero while data_out_valid low");

    no_stream_in_ntt: assert property (@(posedge clk) disable iff (rst)
        (state == poly_pkg::ST_NTT) |-> !$rose(data_out_valid))
        else $error("data_out_valid rose during the transform");

    bfly_reduced: assert property (@(posedge clk) disable iff (rst)
        (s0 < 12'(`POLY_Q)) && (s1 < 12'(`POLY_Q)))
        else $error("butterfly output not reduced mod q");

endmodule

bind poly_unit poly_unit_properties i_props (
    .clk            (clk),
    .rst            (rst),
    .done           (done),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .state          (i_ctrl.state),
    .s0             (i_bfly.s0),
    .s1             (i_bfly.s1)
);

/* tb_poly_unit.sv */
`timescale 1ns/1ps
`include "poly_defs.svh"

module tb_poly_unit;

    logic             clk;
    logic             rst;
    poly_pkg::mode_t  mode;
    logic             run;
    poly_pkg::coeff_t data_in;
    poly_pkg::addr_t  data_in_add;
    logic             data_in_done;
    poly_pkg::coeff_t data_out;
    logic             data_out_valid;
    logic             done;

    logic [11:0]      stim [2*`POLY_N];    // inputs, then expected transform
    poly_pkg::coeff_t in_coeff [`POLY_N];
    poly_pkg::coeff_t exp_coeff [`POLY_N];
    integer           seed;

    poly_unit i_dut (
        .clk, .rst, .mode, .run, .data_in, .data_in_add, .data_in_done,
        .data_out, .data_out_valid, .done
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // reporting

    task automatic fail_with(input string what);
        begin
            $display("ERROR at %0t: %s", $time, what);
            $display("RESULT: FAIL");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        begin
            if (got != expected) begin
                $display("MISMATCH at %0t: %s got %0d expected %0d",
                         $time, name, got, expected);
                $display("RESULT: FAIL");
                $fatal(1, "simulation stopped");
            end
        end
    endtask

    //////////////////////////////////////////////////
    // bus tasks

    task automatic do_run(input poly_pkg::mode_t m);
        begin
            @(posedge clk);
            mode <= m;
            run  <= 1'b1;
            @(posedge clk);
            run  <= 1'b0;
        end
    endtask

    task automatic wait_done(input int limit);
        int   n;
        logic seen;
        begin
            seen = 1'b0;
            for (n = 0; n < limit && !seen; n++) begin
                @(negedge clk);
                if (done) seen = 1'b1;
            end
            if (!seen) fail_with("timeout while waiting for done");
        end
    endtask

    // nothing on the outputs for n cycles
    task automatic quiet_check(input int n);
        int k;
        begin
            for (k = 0; k < n; k++) begin
                @(negedge clk);
                check_value("done", done, 0);
                check_value("data_out_valid", data_out_valid, 0);
                check_value("data_out", data_out, 0);
            end
        end
    endtask

    task automatic do_load;
        int perm [`POLY_N];
        int k;
        int r;
        int tmp;
        begin
            for (k = 0; k < `POLY_N; k++) perm[k] = k;
            for (k = `POLY_N - 1; k > 0; k--) begin     // shuffle addresses
                r       = $unsigned($random(seed)) % (k + 1);
                tmp     = perm[k];
                perm[k] = perm[r];
                perm[r] = tmp;
            end
            do_run(`POLY_MODE_LOAD);
            for (k = 0; k < `POLY_N; k++) begin
                @(posedge clk);
                data_in     <= in_coeff[perm[k]];
                data_in_add <= 5'(perm[k]);
            end
            @(posedge clk);
            data_in_done <= 1'b1;
            @(posedge clk);
            data_in_done <= 1'b0;
            wait_done(10);
        end
    endtask

    task automatic do_unload(input poly_pkg::coeff_t ref_vals [`POLY_N]);
        int got;
        int n;
        begin
            do_run(`POLY_MODE_UNLOAD);
            got = 0;
            n   = 0;
            while (got < `POLY_N && n < 100) begin
                @(negedge clk);
                n++;
                if (data_out_valid) begin
                    check_value($sformatf("data_out[%0d]", got), data_out, ref_vals[got]);
                    got++;
                end else if (got > 0) begin
                    fail_with("data_out_valid dropped before all 32 words");
                end
            end
            if (got < `POLY_N) fail_with("timeout while collecting unload data");
            wait_done(1);                                       // right after the last word
            check_value("data_out_valid", data_out_valid, 0);   // exactly 32 words
            quiet_check(8);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    initial begin
        rst          <= 1'b1;
        mode         <= `POLY_MODE_NTT;
        run          <= 1'b0;
        data_in      <= '0;
        data_in_add  <= '0;
        data_in_done <= 1'b0;
        seed         = 75;

        $readmemh("poly_stimulus.txt", stim);
        if ($isunknown(stim[2*`POLY_N-1])) fail_with("stimulus file could not be read");
        for (int k = 0; k < `POLY_N; k++) begin
            in_coeff[k]  = stim[k];
            exp_coeff[k] = stim[`POLY_N + k];
        end

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        quiet_check(10);                        // idle after reset

        do_load();                              // load then read back
        do_unload(in_coeff);

        do_run(`POLY_MODE_NTT);                 // plain transform
        wait_done(400);
        quiet_check(5);
        do_unload(exp_coeff);

        do_load();                              // transform with a stray run
        do_run(`POLY_MODE_NTT);
        do_run(`POLY_MODE_UNLOAD);              // must be ignored
        wait_done(400);
        quiet_check(20);
        do_unload(exp_coeff);

        do_run(`POLY_MODE_INTT);                // reserved code
        quiet_check(100);
        do_unload(exp_coeff);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* poly_stimulus.txt */
// lines 1-32: input coefficients a[0..31], hex
// lines 33-64: expected forward NTT output for addresses 0..31, hex
003
001
000
000
000
000
000
000
007
000
000
000
000
000
000
000
005
000
000
000
000
000
000
000
000
000
000
000
000
000
000
000
174
C25
9DB
3BE
587
812
610
789
124
35A
277
207
AFF
680
774
A0B
9BB
B98
C57
8FC
640
212
26A
5E8
2B1
A01
497
81B
10E
BA4
98E
324

/* vlog.f */
+incdir+.
poly_pkg.sv
poly_ctrl.sv
coeff_bank.sv
twiddle_rom.sv
mod_butterfly.sv
ntt_sequencer.sv
poly_unloader.sv
poly_unit.sv
poly_unit_properties.sv
tb_poly_unit.sv

/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall -Wno-fatal --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
TOP        ?= tb_poly_unit
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
